//--- src/pdp8_defines.svh
// PDP-8 accumulator path constants: word width, opcode values and operate microcode bits
`ifndef PDP8_DEFINES_SVH
`define PDP8_DEFINES_SVH

`define PDP8_WORD_BITS 12

////////////////////
// opcode field, bits 0 to 2
`define PDP8_OP_AND 3'd0
`define PDP8_OP_TAD 3'd1
`define PDP8_OP_OPR 3'd7

////////////////////
// group 1 microcode, indexed by PDP-8 bit number
`define PDP8_G1_CLA 4
`define PDP8_G1_CLL 5
`define PDP8_G1_CMA 6
`define PDP8_G1_CML 7
`define PDP8_G1_RAR 8
`define PDP8_G1_RAL 9
`define PDP8_G1_TWO 10  // rotate twice, or BSW when no rotate is set
`define PDP8_G1_IAC 11

////////////////////
// group 2 microcode; bit 11 set in group 2 space selects group 3
`define PDP8_G2_CLA 4
`define PDP8_G2_SMA 5
`define PDP8_G2_SZA 6
`define PDP8_G2_SNL 7
`define PDP8_G2_REV 8
`define PDP8_G2_OSR 9
`define PDP8_G2_HLT 10
`define PDP8_G3_SEL 11

`endif

//--- src/pdp8_pkg.sv
// shared types for the PDP-8 accumulator pipeline: words, instruction views and stage bundles
`include "pdp8_defines.svh"

package pdp8_pkg;

    typedef logic [0:`PDP8_WORD_BITS-1] word_t;  // bit 0 is the msb

    ////////////////////
    // two views of one instruction word

    typedef struct packed {
        logic [0:2] opcode;
        logic       indirect;
        logic       page;      // current page when set
        logic [0:6] offset;
    } mri_t;

    typedef struct packed {
        logic [0:2]  opcode;
        logic        group;    // 0 selects group 1
        logic [4:11] micro;
    } opr_t;

    typedef union packed {
        mri_t mri;
        opr_t opr;
    } instr_u;

    ////////////////////
    // stage bundles

    typedef struct packed {
        logic  valid;
        logic  is_and;
        logic  is_tad;
        word_t operand;     // memory operand for AND and TAD
        logic  cla;
        logic  cll;
        logic  cma;
        logic  cml;
        logic  iac;
        logic  rot_right;
        logic  rot_left;
        logic  rot_twice;
        logic  bsw;
        logic  sma;
        logic  sza;
        logic  snl;
        logic  reverse;     // AND group, skip on the complemented tests
        logic  cla2;
        logic  osr;
        logic  hlt;
        word_t sr;          // switch register for OSR
    } op_bundle_t;

    typedef struct packed {
        logic  valid;
        word_t ac;
        logic  link;
        logic  skip;
        logic  hlt;
    } result_t;

endpackage

//--- src/opr_decode.sv
// decode stage that registers a started instruction and expands it into an operation bundle
`include "pdp8_defines.svh"

module opr_decode
    import pdp8_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       halted,
    input  word_t      instruction,
    input  word_t      mem_data,
    input  word_t      sr,
    output op_bundle_t op
);

    instr_u     iw;
    op_bundle_t op_n;

    assign iw = instruction;  // the same word is read as MRI or as operate

    ////////////////////
    // flag expansion

    always_comb
    begin
        op_n         = '0;
        op_n.valid   = start & ~halted;  // a halted machine takes no new work
        op_n.operand = mem_data;
        op_n.sr      = sr;

        case (iw.mri.opcode)
            `PDP8_OP_AND:
            begin
                op_n.is_and = 1'b1;
            end
            `PDP8_OP_TAD:
            begin
                op_n.is_tad = 1'b1;
            end
            `PDP8_OP_OPR:
            begin
                if (!iw.opr.group)
                begin
                    op_n.cla       = iw.opr.micro[`PDP8_G1_CLA];
                    op_n.cll       = iw.opr.micro[`PDP8_G1_CLL];
                    op_n.cma       = iw.opr.micro[`PDP8_G1_CMA];
                    op_n.cml       = iw.opr.micro[`PDP8_G1_CML];
                    op_n.iac       = iw.opr.micro[`PDP8_G1_IAC];
                    op_n.rot_right = iw.opr.micro[`PDP8_G1_RAR];
                    op_n.rot_left  = iw.opr.micro[`PDP8_G1_RAL];
                    op_n.rot_twice = iw.opr.micro[`PDP8_G1_TWO];
                    // with no rotate selected, bit 10 means byte swap on the 8/e
                    op_n.bsw       = iw.opr.micro[`PDP8_G1_TWO]
                                   & ~iw.opr.micro[`PDP8_G1_RAR]
                                   & ~iw.opr.micro[`PDP8_G1_RAL];
                end
                else if (!iw.opr.micro[`PDP8_G3_SEL])
                begin
                    op_n.cla2    = iw.opr.micro[`PDP8_G2_CLA];
                    op_n.sma     = iw.opr.micro[`PDP8_G2_SMA];
                    op_n.sza     = iw.opr.micro[`PDP8_G2_SZA];
                    op_n.snl     = iw.opr.micro[`PDP8_G2_SNL];
                    op_n.reverse = iw.opr.micro[`PDP8_G2_REV];
                    op_n.osr     = iw.opr.micro[`PDP8_G2_OSR];
                    op_n.hlt     = iw.opr.micro[`PDP8_G2_HLT];
                end
            end
            default:
            begin
                // ISZ, DCA, JMS, JMP and IOT only report done
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            op <= '0;
        end
        else
        begin
            op <= op_n;
        end
    end

endmodule

//--- src/opr_execute.sv
// execute stage: owns the accumulator and link and applies one decoded operation per cycle
module opr_execute
    import pdp8_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  op_bundle_t op,
    output result_t    res
);

    word_t       ac_q;
    logic        link_q;
    logic        valid_q;
    logic        skip_q;
    logic        hlt_q;

    word_t       ac_n;
    logic        link_n;
    logic        skip_n;
    logic [0:12] sum;     // carry in bit 0
    logic [0:12] inc;
    logic [0:12] lac;     // link in bit 0, then the accumulator
    logic        or_hit;

    ////////////////////
    // next accumulator and link

    always_comb
    begin
        ac_n   = ac_q;
        link_n = link_q;
        sum    = '0;
        inc    = '0;

        // memory reference
        if (op.is_and)
        begin
            ac_n = ac_q & op.operand;
        end
        else if (op.is_tad)
        begin
            sum  = {1'b0, ac_q} + {1'b0, op.operand};
            ac_n = sum[1:12];
            if (sum[0])
            begin
                link_n = ~link_q;  // carry out flips the link
            end
        end

        // group 1, in machine order
        if (op.cla)
        begin
            ac_n = '0;
        end
        if (op.cll)
        begin
            link_n = 1'b0;
        end
        if (op.cma)
        begin
            ac_n = ~ac_n;
        end
        if (op.cml)
        begin
            link_n = ~link_n;
        end
        if (op.iac)
        begin
            inc    = {link_n, ac_n} + 13'd1;  // overflow out of ac toggles the link
            link_n = inc[0];
            ac_n   = inc[1:12];
        end

        lac = {link_n, ac_n};
        if (op.rot_right)
        begin
            lac = {lac[12], lac[0:11]};
            if (op.rot_twice)
            begin
                lac = {lac[12], lac[0:11]};
            end
        end
        else if (op.rot_left)
        begin
            lac = {lac[1:12], lac[0]};
            if (op.rot_twice)
            begin
                lac = {lac[1:12], lac[0]};
            end
        end
        else if (op.bsw)
        begin
            lac[1:12] = {lac[7:12], lac[1:6]};  // link is not involved
        end
        link_n = lac[0];
        ac_n   = lac[1:12];

        // group 2, tests see the state from before CLA
        or_hit = (op.sma & ac_q[0])
               | (op.sza & (ac_q == '0))
               | (op.snl & link_q);
        skip_n = op.reverse ? ~or_hit : or_hit;

        if (op.cla2)
        begin
            ac_n = '0;
        end
        if (op.osr)
        begin
            ac_n = ac_n | op.sr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ac_q    <= '0;
            link_q  <= 1'b0;
            valid_q <= 1'b0;
            skip_q  <= 1'b0;
            hlt_q   <= 1'b0;
        end
        else
        begin
            valid_q <= op.valid;
            if (op.valid)
            begin
                ac_q   <= ac_n;
                link_q <= link_n;
                skip_q <= skip_n;
                hlt_q  <= op.hlt;
            end
        end
    end

    assign res = '{valid: valid_q, ac: ac_q, link: link_q, skip: skip_q, hlt: hlt_q};

endmodule

//--- src/opr_result.sv
// result stage: registers the committed state and turns it into done, skip and halt outputs
module opr_result
    import pdp8_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  result_t res,
    output word_t   ac,
    output logic    link,
    output logic    skip,
    output logic    done,
    output logic    halted
);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ac     <= '0;
            link   <= 1'b0;
            skip   <= 1'b0;
            done   <= 1'b0;
            halted <= 1'b0;
        end
        else
        begin
            done <= res.valid;               // one pulse per finished instruction
            skip <= res.valid & res.skip;
            if (res.valid)
            begin
                ac   <= res.ac;
                link <= res.link;
            end
            if (res.valid && res.hlt)
            begin
                halted <= 1'b1;              // held until reset
            end
        end
    end

endmodule

//--- src/pdp8_opr_unit.sv
// PDP-8/e accumulator path top level: decode, execute and result stages in a pipeline
module pdp8_opr_unit
    import pdp8_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  word_t instruction,
    input  word_t mem_data,
    input  word_t sr,
    output word_t ac,
    output logic  link,
    output logic  skip,
    output logic  done,
    output logic  halted
);

    op_bundle_t op;
    result_t    res;

    opr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .halted      (halted),  // fed back from the result stage
        .instruction (instruction),
        .mem_data    (mem_data),
        .sr          (sr),
        .op          (op)
    );

    opr_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op),
        .res   (res)
    );

    opr_result u_result (
        .clk    (clk),
        .rst_n  (rst_n),
        .res    (res),
        .ac     (ac),
        .link   (link),
        .skip   (skip),
        .done   (done),
        .halted (halted)
    );

endmodule

//--- tests/opr_vectors.svh
// accumulator pipeline vector table: stimulus rows with hand-worked AC, link and skip values
`ifndef OPR_VECTORS_SVH
`define OPR_VECTORS_SVH

    // columns: instruction, mem_data, sr, back_to_back, expected ac, link, skip (words in octal)
    // back_to_back rows start on the cycle after the row before, without waiting for done

    typedef struct packed {
        word_t instruction;
        word_t mem_data;
        word_t sr;
        logic  back_to_back;
        word_t exp_ac;
        logic  exp_link;
        logic  exp_skip;
    } vector_t;

    vector_t vectors [$];

    task automatic add_row(input word_t instr, input word_t data, input word_t switches,
                           input logic b2b, input word_t exp_ac, input logic exp_link,
                           input logic exp_skip);
        vector_t v;
        v = '{instr, data, switches, b2b, exp_ac, exp_link, exp_skip};
        vectors.push_back(v);
    endtask

    task automatic load_vectors();
        ////////////////////
        // clears and memory reference
        add_row(12'o7300, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b0, 1'b0);  // CLA CLL
        add_row(12'o7340, 12'o0000, 12'o0000, 1'b0, 12'o7777, 1'b0, 1'b0);  // CLA CLL CMA
        add_row(12'o1020, 12'o0001, 12'o0000, 1'b0, 12'o0000, 1'b1, 1'b0);  // TAD, carry flips L
        add_row(12'o1020, 12'o1234, 12'o0000, 1'b0, 12'o1234, 1'b1, 1'b0);  // TAD
        add_row(12'o0020, 12'o0707, 12'o0000, 1'b0, 12'o0204, 1'b1, 1'b0);  // AND mask
        ////////////////////
        // group 1 sequence and rotates
        add_row(12'o7041, 12'o0000, 12'o0000, 1'b0, 12'o7574, 1'b1, 1'b0);  // CMA IAC negates
        add_row(12'o7104, 12'o0000, 12'o0000, 1'b0, 12'o7370, 1'b1, 1'b0);  // CLL RAL
        add_row(12'o7012, 12'o0000, 12'o0000, 1'b0, 12'o3676, 1'b0, 1'b0);  // RTR
        add_row(12'o7002, 12'o0000, 12'o0000, 1'b0, 12'o7636, 1'b0, 1'b0);  // BSW
        add_row(12'o7021, 12'o0000, 12'o0000, 1'b0, 12'o7637, 1'b1, 1'b0);  // CML IAC
        add_row(12'o7010, 12'o0000, 12'o0000, 1'b0, 12'o7717, 1'b1, 1'b0);  // RAR
        add_row(12'o7006, 12'o0000, 12'o0000, 1'b0, 12'o7477, 1'b1, 1'b0);  // RTL
        ////////////////////
        // group 2 skips, CLA after the test, OSR
        add_row(12'o7500, 12'o0000, 12'o0000, 1'b0, 12'o7477, 1'b1, 1'b1);  // SMA
        add_row(12'o7440, 12'o0000, 12'o0000, 1'b0, 12'o7477, 1'b1, 1'b0);  // SZA
        add_row(12'o7420, 12'o0000, 12'o0000, 1'b0, 12'o7477, 1'b1, 1'b1);  // SNL
        add_row(12'o7700, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b1, 1'b1);  // SMA CLA
        add_row(12'o7510, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b1, 1'b1);  // SPA
        add_row(12'o7450, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b1, 1'b0);  // SNA
        add_row(12'o7430, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b1, 1'b0);  // SZL with L set
        add_row(12'o7410, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b1, 1'b1);  // SKP
        add_row(12'o7100, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b0, 1'b0);  // CLL
        add_row(12'o7430, 12'o0000, 12'o0000, 1'b0, 12'o0000, 1'b0, 1'b1);  // SZL
        add_row(12'o7404, 12'o0000, 12'o5252, 1'b0, 12'o5252, 1'b0, 1'b0);  // OSR
        add_row(12'o7604, 12'o0000, 12'o1234, 1'b0, 12'o1234, 1'b0, 1'b0);  // CLA OSR
        add_row(12'o7550, 12'o0000, 12'o0000, 1'b0, 12'o1234, 1'b0, 1'b1);  // SPA SNA
        ////////////////////
        // three starts on consecutive cycles
        add_row(12'o1020, 12'o0001, 12'o0000, 1'b0, 12'o1235, 1'b0, 1'b0);  // TAD
        add_row(12'o1020, 12'o0002, 12'o0000, 1'b1, 12'o1237, 1'b0, 1'b0);  // TAD
        add_row(12'o7040, 12'o0000, 12'o0000, 1'b1, 12'o6540, 1'b0, 1'b0);  // CMA
        ////////////////////
        // instructions that only report done, then the halt
        add_row(12'o3000, 12'o7777, 12'o0000, 1'b0, 12'o6540, 1'b0, 1'b0);  // DCA
        add_row(12'o5123, 12'o7777, 12'o0000, 1'b0, 12'o6540, 1'b0, 1'b0);  // JMP
        add_row(12'o6046, 12'o7777, 12'o0000, 1'b0, 12'o6540, 1'b0, 1'b0);  // IOT
        add_row(12'o7401, 12'o0000, 12'o0000, 1'b0, 12'o6540, 1'b0, 1'b0);  // group 3
        add_row(12'o7402, 12'o0000, 12'o0000, 1'b0, 12'o6540, 1'b0, 1'b0);  // HLT, must be last
    endtask

`endif

//--- tests/opr_unit_tb.sv
// accumulator pipeline testbench that runs the vector table and checks done, AC, link, skip and halt
module opr_unit_tb
    import pdp8_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int IN_DELAY     = 2;
    localparam int LATENCY      = 3;  // a start driven in cycle n shows done in cycle n+3

    typedef struct packed {
        int row;
        int due;
    } pending_t;

    logic     clk;
    logic     rst_n;
    logic     start;
    word_t    instruction;
    word_t    mem_data;
    word_t    sr;
    word_t    ac;
    logic     link;
    logic     skip;
    logic     done;
    logic     halted;

    int       cycle = 0;
    int       pass_count;
    int       fail_count;
    pending_t pending [$];  // started rows still waiting for done

    `include "opr_vectors.svh"

    pdp8_opr_unit UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .instruction (instruction),
        .mem_data    (mem_data),
        .sr          (sr),
        .ac          (ac),
        .link        (link),
        .skip        (skip),
        .done        (done),
        .halted      (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    always @(negedge clk)
    begin
        watch_done();  // outputs are stable half a cycle after the edge
    end

    ////////////////////
    // checks and reporting

    task automatic check_word(input string name, input word_t expected, input word_t actual,
                              inout bit ok);
        assert (actual === expected)
        else
        begin
            $display("ERROR at %0d ns: %s expected %04o, got %04o", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual,
                             inout bit ok);
        assert (actual === expected)
        else
        begin
            $display("ERROR at %0d ns: %s expected %0b, got %0b", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok)
        begin
            pass_count++;
            $display("%s: pass", name);
        end
        else
        begin
            fail_count++;
            $display("%s: FAIL", name);
        end
    endtask

    task automatic score_row(input pending_t head);
        vector_t v;
        bit      ok;
        v  = vectors[head.row];
        ok = 1'b1;
        assert (head.due == cycle)
        else
        begin
            $display("row %0d: done came in cycle %0d, not in cycle %0d", head.row + 1, cycle,
                     head.due);
            ok = 1'b0;
        end
        check_word("ac", v.exp_ac, ac, ok);
        check_bit("link", v.exp_link, link, ok);
        check_bit("skip", v.exp_skip, skip, ok);
        report_test($sformatf("row %0d instruction %04o", head.row + 1, v.instruction), ok);
    endtask

    task automatic watch_done();
        pending_t head;
        if (done)
        begin
            assert (pending.size() != 0)
            else
            begin
                $display("done pulsed at %0d ns with no instruction in flight", $time);
                fail_count++;
            end
            if (pending.size() != 0)
            begin
                head = pending.pop_front();
                score_row(head);
            end
        end
        else if (pending.size() != 0)
        begin
            head = pending[0];
            assert (head.due > cycle)
            else
            begin
                head = pending.pop_front();
                $display("row %0d: done missing 2 edges after its start was sampled",
                         head.row + 1);
                fail_count++;
            end
        end
    endtask

    ////////////////////
    // stimulus

    task automatic check_reset_state();
        bit ok;
        ok = 1'b1;
        @(negedge clk);
        check_word("ac", 12'o0000, ac, ok);
        check_bit("link", 1'b0, link, ok);
        check_bit("skip", 1'b0, skip, ok);
        check_bit("done", 1'b0, done, ok);
        check_bit("halted", 1'b0, halted, ok);
        report_test("reset state", ok);
    endtask

    task automatic run_table();
        pending_t entry;
        for (int i = 0; i < vectors.size(); i++)
        begin
            @(posedge clk);
            #IN_DELAY;
            if (!vectors[i].back_to_back)
            begin
                start = 1'b0;
                while (pending.size() != 0)
                begin
                    @(posedge clk);
                    #IN_DELAY;
                end
            end
            start       = 1'b1;
            instruction = vectors[i].instruction;
            mem_data    = vectors[i].mem_data;
            sr          = vectors[i].sr;
            entry.row   = i;
            entry.due   = cycle + LATENCY;
            pending.push_back(entry);
        end
        @(posedge clk);
        #IN_DELAY;
        start = 1'b0;
        while (pending.size() != 0)
        begin
            @(posedge clk);
        end
    endtask

    task automatic check_halt_hold();
        word_t held_ac;
        bit    ok;
        held_ac = vectors[vectors.size() - 1].exp_ac;
        ok      = 1'b1;
        @(negedge clk);
        check_bit("halted", 1'b1, halted, ok);
        @(posedge clk);
        #IN_DELAY;
        start       = 1'b1;
        instruction = 12'o1020;  // a TAD that would move AC if it ran
        mem_data    = 12'o0001;
        @(posedge clk);
        #IN_DELAY;
        start = 1'b0;
        repeat (4)
        begin
            @(negedge clk);
            check_bit("done", 1'b0, done, ok);
            check_word("ac", held_ac, ac, ok);
        end
        report_test("start dropped while halted", ok);
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        instruction = '0;
        mem_data    = '0;
        sr          = '0;
        pass_count  = 0;
        fail_count  = 0;
        load_vectors();

        repeat (RESET_CYCLES) @(posedge clk);
        #IN_DELAY;
        rst_n = 1'b1;
        check_reset_state();
        run_table();
        check_halt_hold();

        $display("summary: %0d passed, %0d failing", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    // the watchdog allows ten cycles per table row on top of reset
    initial
    begin
        int limit_ns;
        #1;  // the table is loaded at time zero
        limit_ns = (vectors.size() * 10 + RESET_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog: the run did not finish within %0d ns", limit_ns);
        $display("tests failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+src
+incdir+tests
src/pdp8_pkg.sv
src/opr_decode.sv
src/opr_execute.sv
src/opr_result.sv
src/pdp8_opr_unit.sv
tests/opr_unit_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and log to $(LOG)"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module opr_unit_tb -f files.f -Mdir obj_dir -o opr_unit_sim
	./obj_dir/opr_unit_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "FAIL: no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
